// ==== dv/conv_engine_stimulus.txt ====
// per frame: bias relu / nine weights (window raster order) / 8 rows of 8 pixels /
// 6 rows of 6 expected outputs; all words are 16-bit two's complement hex
// frame 1: rectifier off, large weights, saturating windows
0064 0000
0100 0200 0100 0200 0300 0200 0080 0041 003F
EF34 EF98 EFFC F060 F0C4 F128 F18C F1F0
F3E4 F448 F4AC F510 F574 F5D8 F63C F6A0
F894 F8F8 F95C F9C0 FA24 FA88 FAEC FB50
FD44 FDA8 FE0C FE70 FED4 FF38 FF9C 0000
01F4 0258 02BC 0320 0384 03E8 044C 04B0
06A4 0708 076C 07D0 0834 0898 08FC 0960
0B54 0BB8 0C1C 0C80 0CE4 0D48 0DAC 0E10
1004 1068 10CC 1130 1194 11F8 125C 12C0
8000 8000 8000 8000 8000 8000
9DDA A28A A73A ABEA B09A B54A
D61A DACA DF7A E42A E8DA ED8A
0E5A 130A 17BA 1C6A 211A 25CA
469A 4B4A 4FFA 54AA 595A 5E0A
7EDA 7FFF 7FFF 7FFF 7FFF 7FFF
// frame 2: rectifier on, negative bias
FE0C 0001
FF80 0040 0000 0020 0100 0020 0000 0040 FFC0
03E8 040D 0432 0457 047C 04A1 04C6 04EB
0352 0377 039C 03C1 03E6 040B 0430 0455
02BC 02E1 0306 032B 0350 0375 039A 03BF
0226 024B 0270 0295 02BA 02DF 0304 0329
0190 01B5 01DA 01FF 0224 0249 026E 0293
00FA 011F 0144 0169 018E 01B3 01D8 01FD
0064 0089 00AE 00D3 00F8 011D 0142 0167
FFCE FFF3 0018 003D 0062 0087 00AC 00D1
0166 018B 01B0 01D5 01FA 021F
00D0 00F5 011A 013F 0164 0189
003A 005F 0084 00A9 00CE 00F3
0000 0000 0000 0013 0038 005D
0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000

// ==== dv/conv_engine_tb.sv ====
// Testbench for the streaming 3x3 convolution engine.
// Loads weights, pixels and expected outputs for two frames from the stimulus
// file, feeds pixels with random idle gaps and checks every output value, its
// latency, the done pulse and the order of engine states.

`timescale 1ns/1ps

module conv_engine_tb;
   import conv_geom_pkg::*;
   import conv_types_pkg::*;

   localparam int CLK_PERIOD  = 20;
   localparam int DRV_DLY     = 2;
   localparam int RST_CYCLES  = 16;
   localparam int MAX_GAP     = 3;     // worst case idle cycles before a pixel
   localparam int N_FRAMES    = 2;
   localparam int N_PIX       = IMG_W * IMG_H;
   localparam int OUT_W       = IMG_W - FILT + 1;
   localparam int N_OUT       = OUT_W * (IMG_H - FILT + 1);
   localparam int FRAME_WORDS = 2 + N_TAPS + N_PIX + N_OUT;
   localparam int EXP_OFS     = 2 + N_TAPS + N_PIX;   // first expected word of a frame
   localparam int WD_CYCLES   = RST_CYCLES + N_PIX + 40 +
                                N_FRAMES * (N_PIX * (MAX_GAP + 1) + N_TAPS + PIPE_LAT + 20);
   localparam logic [31:0] SEED = 32'h21974223;

   logic          clk;
   logic          rst_n;
   logic          start;
   logic          pixel_valid;
   pixel_t        pixel;
   logic          weight_we;
   tap_idx_t      weight_addr;
   weight_t       weight;
   pixel_t        bias;
   logic          relu_en;
   logic          y_valid;
   pixel_t        y;
   logic          done;
   engine_state_e state;

   logic [15:0]   stim_mem [N_FRAMES * FRAME_WORDS];
   int            due_edge [N_FRAMES * N_OUT];   // edge where each output is due
   int            n_due = 0;
   int            cyc = 0;                       // rising edges so far
   int            last_acc_edge = 0;
   int            out_cnt = 0;
   int            done_cnt = 0;
   engine_state_e prev_state = IDLE;
   string         test_name = "reset";

   conv_engine u_conv_engine (
      .clk           (clk),
      .rst_n         (rst_n),
      .start_i       (start),
      .pixel_valid_i (pixel_valid),
      .pixel_i       (pixel),
      .weight_we_i   (weight_we),
      .weight_addr_i (weight_addr),
      .weight_i      (weight),
      .bias_i        (bias),
      .relu_en_i     (relu_en),
      .y_valid_o     (y_valid),
      .y_o           (y),
      .done_o        (done),
      .state_o       (state)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_eq(input string what, input int expected, input int actual);
      assert (expected == actual)
      else abort_run($sformatf("ERR %s %s: expected %0d, actual %0d",
                               test_name, what, expected, actual));
   endtask

   task automatic wait_drive_slot();
      @(posedge clk);
      #DRV_DLY;
   endtask

   task automatic load_weights(input int base);
      for (int k = 0; k < N_TAPS; k++) begin
         wait_drive_slot();
         weight_we   = 1'b1;
         weight_addr = tap_idx_t'(k);
         weight      = weight_t'(stim_mem[base + 2 + k]);
      end
      wait_drive_slot();
      weight_we = 1'b0;
   endtask

   task automatic run_frame(input int f);
      int base;
      int gap;
      int row;
      int col;
      base      = f * FRAME_WORDS;
      test_name = $sformatf("frame%0d", f + 1);
      bias      = pixel_t'(stim_mem[base]);
      relu_en   = stim_mem[base + 1][0];
      load_weights(base);
      start = 1'b1;
      wait_drive_slot();
      start = 1'b0;
      for (int p = 0; p < N_PIX; p++) begin
         gap = $urandom % (MAX_GAP + 1);
         pixel_valid = 1'b0;
         repeat (gap) wait_drive_slot();
         row         = p / IMG_W;
         col         = p % IMG_W;
         pixel_valid = 1'b1;
         pixel       = pixel_t'(stim_mem[base + 2 + N_TAPS + p]);
         // bottom right corner of a full window
         if (row >= FILT - 1 && col >= FILT - 1) begin
            due_edge[n_due] = cyc + 1 + PIPE_LAT;
            n_due           = n_due + 1;
         end
         last_acc_edge = cyc + 1;
         wait_drive_slot();
      end
      pixel_valid = 1'b0;
      while (done_cnt < f + 1) wait_drive_slot();
      check_eq("outputs so far", (f + 1) * N_OUT, out_cnt);
      check_eq("state_o after done", int'(IDLE), int'(state));
   endtask

   // output, done and state monitor, sampled away from the rising edge
   always @(negedge clk) begin
      engine_state_e next_state;
      if (rst_n) begin
         if (y_valid) begin
            assert (out_cnt < n_due)
            else abort_run("an output strobe came with no complete window pending");
            check_eq($sformatf("output %0d edge", out_cnt), due_edge[out_cnt], cyc);
            if (relu_en) begin
               assert (y >= 0)
               else abort_run($sformatf("ERR %s output %0d sign: expected >= 0, actual %0d",
                                        test_name, out_cnt, y));
            end
            check_eq($sformatf("output %0d value", out_cnt),
                     int'(pixel_t'(stim_mem[(out_cnt / N_OUT) * FRAME_WORDS + EXP_OFS
                                            + out_cnt % N_OUT])),
                     int'(y));
            out_cnt = out_cnt + 1;
         end
         if (done) begin
            check_eq("done_o edge", last_acc_edge + PIPE_LAT, cyc);
            check_eq("state_o at done", int'(IDLE), int'(state));
            done_cnt = done_cnt + 1;
         end
         if (state != prev_state) begin
            case (prev_state)
               IDLE:    next_state = PRELOAD;
               PRELOAD: next_state = RUN;
               RUN:     next_state = DRAIN;
               default: next_state = IDLE;
            endcase
            assert (state == next_state)
            else abort_run($sformatf("state_o moved from %0d to %0d out of order",
                                     prev_state, state));
            prev_state = state;
         end
      end
   end

   initial begin
      void'($urandom(SEED));
      rst_n       = 1'b0;
      start       = 1'b0;
      pixel_valid = 1'b0;
      pixel       = '0;
      weight_we   = 1'b0;
      weight_addr = '0;
      weight      = '0;
      bias        = '0;
      relu_en     = 1'b0;
      $readmemh("dv/conv_engine_stimulus.txt", stim_mem);
      repeat (RST_CYCLES) @(posedge clk);
      #DRV_DLY;
      rst_n = 1'b1;

      wait_drive_slot();
      check_eq("y_valid_o", 0, int'(y_valid));
      check_eq("done_o", 0, int'(done));
      check_eq("state_o", int'(IDLE), int'(state));

      // a whole frame offered in IDLE must be dropped
      test_name   = "idle_pixels";
      pixel_valid = 1'b1;
      for (int i = 0; i < N_PIX; i++) begin
         pixel = pixel_t'(i * 97);
         wait_drive_slot();
      end
      pixel_valid = 1'b0;
      repeat (PIPE_LAT + 2) wait_drive_slot();
      check_eq("outputs", 0, out_cnt);
      check_eq("state_o", int'(IDLE), int'(state));

      for (int f = 0; f < N_FRAMES; f++) begin
         run_frame(f);
      end
      test_name = "summary";
      check_eq("done pulses", N_FRAMES, done_cnt);
      $display("ALL TESTS PASSED");
      $finish;
   end

   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      abort_run($sformatf("watchdog: the run did not finish within %0d clock cycles",
                          WD_CYCLES));
   end

endmodule

// ==== hw/conv_engine.sv ====
// Top level of the streaming 3x3 convolution engine.
// Pixels enter one per pixel_valid_i strobe in raster order; each full
// window leaves as one y_valid_o strobe PIPE_LAT cycles after its last pixel.
// Weights are loaded through the write port before start_i.

`timescale 1ns/1ps

module conv_engine (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          start_i,
   input  logic                          pixel_valid_i,
   input  conv_types_pkg::pixel_t        pixel_i,
   input  logic                          weight_we_i,
   input  conv_types_pkg::tap_idx_t      weight_addr_i,
   input  conv_types_pkg::weight_t       weight_i,
   input  conv_types_pkg::pixel_t        bias_i,
   input  logic                          relu_en_i,
   output logic                          y_valid_o,
   output conv_types_pkg::pixel_t        y_o,
   output logic                          done_o,
   output conv_types_pkg::engine_state_e state_o
);
   import conv_geom_pkg::*;
   import conv_types_pkg::*;

   logic   accept;
   logic   frame_start;
   logic   first_win;
   logic   last_pix;
   logic   win_valid;
   pixel_t win [N_TAPS];
   logic   sop_valid;
   acc_t   sum;

   conv_engine_fsm u_fsm (
      .clk           (clk),
      .rst_n         (rst_n),
      .start_i       (start_i),
      .pixel_valid_i (pixel_valid_i),
      .first_win_i   (first_win),
      .last_pix_i    (last_pix),
      .accept_o      (accept),
      .frame_start_o (frame_start),
      .done_o        (done_o),
      .state_o       (state_o)
   );

   conv_linebuffer u_linebuffer (
      .clk           (clk),
      .rst_n         (rst_n),
      .accept_i      (accept),
      .frame_start_i (frame_start),
      .pixel_i       (pixel_i),
      .win_valid_o   (win_valid),
      .win_o         (win),
      .first_win_o   (first_win),
      .last_pix_o    (last_pix)
   );

   conv_sop u_sop (
      .clk           (clk),
      .rst_n         (rst_n),
      .weight_we_i   (weight_we_i),
      .weight_addr_i (weight_addr_i),
      .weight_i      (weight_i),
      .win_valid_i   (win_valid),
      .win_i         (win),
      .sop_valid_o   (sop_valid),
      .sum_o         (sum)
   );

   conv_shift_adder u_shift_adder (
      .clk         (clk),
      .rst_n       (rst_n),
      .sop_valid_i (sop_valid),
      .sum_i       (sum),
      .bias_i      (bias_i),
      .relu_en_i   (relu_en_i),
      .y_valid_o   (y_valid_o),
      .y_o         (y_o)
   );

endmodule

// ==== hw/conv_engine_fsm.sv ====
// Control FSM of the convolution engine.
// IDLE -> PRELOAD on start, PRELOAD -> RUN on the first full window,
// RUN -> DRAIN on the last pixel, DRAIN -> IDLE after PIPE_LAT cycles.
// Pixels are only accepted in PRELOAD and RUN; done_o pulses on leaving DRAIN.

`timescale 1ns/1ps

module conv_engine_fsm (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          start_i,
   input  logic                          pixel_valid_i,
   input  logic                          first_win_i,
   input  logic                          last_pix_i,
   output logic                          accept_o,
   output logic                          frame_start_o,
   output logic                          done_o,
   output conv_types_pkg::engine_state_e state_o
);
   import conv_geom_pkg::*;
   import conv_types_pkg::*;

   engine_state_e      state_q;
   engine_state_e      state_d;
   logic [DRAIN_W-1:0] drain_cnt_q;
   logic               drain_end;

   assign drain_end     = (state_q == DRAIN) && (drain_cnt_q == DRAIN_W'(PIPE_LAT - 1));
   assign accept_o      = pixel_valid_i && ((state_q == PRELOAD) || (state_q == RUN));
   assign frame_start_o = (state_q == IDLE) && start_i;   // clears the raster counters
   assign state_o       = state_q;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE:    if (start_i)     state_d = PRELOAD;
         PRELOAD: if (first_win_i) state_d = RUN;
         RUN:     if (last_pix_i)  state_d = DRAIN;
         DRAIN:   if (drain_end)   state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q     <= IDLE;
         drain_cnt_q <= '0;
         done_o      <= 1'b0;
      end else begin
         state_q <= state_d;
         done_o  <= drain_end;
         // counts cycles spent in DRAIN
         if (state_q == DRAIN) begin
            drain_cnt_q <= drain_cnt_q + 1'b1;
         end else begin
            drain_cnt_q <= '0;
         end
      end
   end

endmodule

// ==== hw/conv_geom_pkg.sv ====
// Frame, filter and fixed-point geometry for the 3x3 convolution engine.
// Imported by every RTL block that sizes storage, counts pixels or
// scales the sum of products.

package conv_geom_pkg;

   // frame size, raster order
   localparam int IMG_W = 8;
   localparam int IMG_H = 8;

   // filter window
   localparam int FILT   = 3;
   localparam int N_TAPS = FILT * FILT;

   localparam int QF = 8;   // fractional bits of the weights

   // pipeline depth
   localparam int SOP_LAT  = 2;              // multiply stage + adder tree stage
   localparam int PIPE_LAT = 1 + SOP_LAT + 1; // accept edge to output strobe
   localparam int DRAIN_W  = $clog2(PIPE_LAT);

   // output sample limits used by the saturation
   localparam int PIX_MAX = 32767;
   localparam int PIX_MIN = -32768;

endpackage

// ==== hw/conv_linebuffer.sv ====
// Line buffer for a raster pixel stream.
// Keeps the two previous rows and a 3x3 window, tracks the raster
// position and flags each pixel that completes a full window.
// The window and win_valid_o appear one cycle after the accepting edge.

`timescale 1ns/1ps

module conv_linebuffer (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   accept_i,
   input  logic                   frame_start_i,
   input  conv_types_pkg::pixel_t pixel_i,
   output logic                   win_valid_o,
   output conv_types_pkg::pixel_t win_o [conv_geom_pkg::N_TAPS],
   output logic                   first_win_o,
   output logic                   last_pix_o
);
   import conv_geom_pkg::*;
   import conv_types_pkg::*;

   col_t   col_q;              // position of the next pixel
   row_t   row_q;
   logic   at_win;
   logic   acc_q;
   logic   hit_q;
   pixel_t pix_q;
   pixel_t line1_q [IMG_W];    // row above
   pixel_t line2_q [IMG_W];    // two rows above
   pixel_t win_q   [N_TAPS];   // raster order, tap 0 top left

   // pixel being accepted is the bottom right corner of a full window
   assign at_win      = accept_i && (col_q >= col_t'(FILT - 1)) && (row_q >= row_t'(FILT - 1));
   assign first_win_o = accept_i && (col_q == col_t'(FILT - 1)) && (row_q == row_t'(FILT - 1));
   assign last_pix_o  = accept_i && (col_q == col_t'(IMG_W - 1)) && (row_q == row_t'(IMG_H - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         col_q <= '0;
         row_q <= '0;
      end else if (frame_start_i) begin
         col_q <= '0;
         row_q <= '0;
      end else if (accept_i) begin
         if (col_q == col_t'(IMG_W - 1)) begin
            col_q <= '0;
            row_q <= (row_q == row_t'(IMG_H - 1)) ? '0 : row_q + 1'b1;
         end else begin
            col_q <= col_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc_q       <= 1'b0;
         hit_q       <= 1'b0;
         win_valid_o <= 1'b0;
      end else begin
         acc_q       <= accept_i;
         hit_q       <= at_win;
         win_valid_o <= hit_q;   // lines up with the window shift below
      end
   end

   always_ff @(posedge clk) begin
      if (accept_i) pix_q <= pixel_i;
      if (acc_q) begin
         line1_q[0] <= pix_q;
         line2_q[0] <= line1_q[IMG_W-1];
         for (int i = 1; i < IMG_W; i++) begin
            line1_q[i] <= line1_q[i-1];
            line2_q[i] <= line2_q[i-1];
         end
         // window moves one column left
         for (int r = 0; r < FILT; r++) begin
            for (int c = 0; c < FILT - 1; c++) begin
               win_q[r*FILT + c] <= win_q[r*FILT + c + 1];
            end
         end
         win_q[FILT-1]        <= line2_q[IMG_W-1];
         win_q[2*FILT-1]      <= line1_q[IMG_W-1];
         win_q[FILT*FILT-1]   <= pix_q;   // bottom right
      end
   end

   assign win_o = win_q;

endmodule

// ==== hw/conv_shift_adder.sv ====
// Output stage of the engine.
// Scales the sum of products down by QF (floor), adds the bias,
// saturates to the sample range and optionally rectifies.
// One register stage, valid travels with the sample.

`timescale 1ns/1ps

module conv_shift_adder (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   sop_valid_i,
   input  conv_types_pkg::acc_t   sum_i,
   input  conv_types_pkg::pixel_t bias_i,
   input  logic                   relu_en_i,
   output logic                   y_valid_o,
   output conv_types_pkg::pixel_t y_o
);
   import conv_geom_pkg::*;
   import conv_types_pkg::*;

   acc_t   scaled_c;
   acc_t   biased_c;
   pixel_t sat_c;
   pixel_t res_c;

   always_comb begin
      scaled_c = sum_i >>> QF;                  // arithmetic, rounds toward -inf
      biased_c = scaled_c + acc_t'(bias_i);
      if (biased_c > acc_t'(PIX_MAX)) begin
         sat_c = pixel_t'(PIX_MAX);
      end else if (biased_c < acc_t'(PIX_MIN)) begin
         sat_c = pixel_t'(PIX_MIN);
      end else begin
         sat_c = pixel_t'(biased_c);
      end
      res_c = (relu_en_i && (sat_c < 0)) ? '0 : sat_c;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         y_valid_o <= 1'b0;
      end else begin
         y_valid_o <= sop_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (sop_valid_i) y_o <= res_c;
   end

endmodule

// ==== hw/conv_sop.sv ====
// Sum of products over one 3x3 window.
// Nine weights are written through a simple write port; tap k of the
// window is multiplied by weight k. Products are registered, then their
// sum, so the result and sop_valid_o follow win_valid_i by SOP_LAT cycles.

`timescale 1ns/1ps

module conv_sop (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     weight_we_i,
   input  conv_types_pkg::tap_idx_t weight_addr_i,
   input  conv_types_pkg::weight_t  weight_i,
   input  logic                     win_valid_i,
   input  conv_types_pkg::pixel_t   win_i [conv_geom_pkg::N_TAPS],
   output logic                     sop_valid_o,
   output conv_types_pkg::acc_t     sum_o
);
   import conv_geom_pkg::*;
   import conv_types_pkg::*;

   weight_t             weight_q [N_TAPS];
   logic signed [$bits(pixel_t)+$bits(weight_t)-1:0] prod_q [N_TAPS];
   acc_t                sum_c;
   logic [SOP_LAT-1:0]  vld_q;   // one bit per pipeline stage

   // weight register file, addresses past the last tap are dropped
   always_ff @(posedge clk) begin
      if (weight_we_i && (weight_addr_i < tap_idx_t'(N_TAPS))) begin
         weight_q[weight_addr_i] <= weight_i;
      end
   end

   // stage 1: nine signed products
   always_ff @(posedge clk) begin
      for (int k = 0; k < N_TAPS; k++) begin
         prod_q[k] <= win_i[k] * weight_q[k];
      end
   end

   // adder tree
   always_comb begin
      sum_c = '0;
      for (int k = 0; k < N_TAPS; k++) begin
         sum_c = sum_c + prod_q[k];
      end
   end

   // stage 2
   always_ff @(posedge clk) begin
      sum_o <= sum_c;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[SOP_LAT-2:0], win_valid_i};
      end
   end

   assign sop_valid_o = vld_q[SOP_LAT-1];

endmodule

// ==== hw/conv_types_pkg.sv ====
// Data and control types for the convolution engine.
// Pixels, weights and the accumulator are signed; the state enum is
// what the engine reports on state_o.

package conv_types_pkg;

   typedef logic signed [15:0] pixel_t;   // input pixel and output sample
   typedef logic signed [15:0] weight_t;
   typedef logic signed [35:0] acc_t;     // nine 32-bit products plus headroom

   typedef logic [3:0] tap_idx_t;         // weight address
   typedef logic [2:0] col_t;
   typedef logic [2:0] row_t;

   // engine control states
   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      PRELOAD = 2'd1,   // filling the line buffer
      RUN     = 2'd2,   // producing windows
      DRAIN   = 2'd3    // last windows still in the pipeline
   } engine_state_e;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Builds the convolution engine testbench with Verilator and runs it.
# Exits 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module conv_engine_tb -o conv_engine_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/conv_engine_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== src.f ====
hw/conv_geom_pkg.sv
hw/conv_types_pkg.sv
hw/conv_linebuffer.sv
hw/conv_sop.sv
hw/conv_shift_adder.sv
hw/conv_engine_fsm.sv
hw/conv_engine.sv
dv/conv_engine_tb.sv
